// File: rvAlu.sv
`timescale 1ns/1ps

module rvAlu import rvPkg::*; (
   input  word_t  opA,
   input  word_t  opB,
   input  aluOp_t aluOp,
   output word_t  aluResult
);

   logic [4:0] shAmt;
   logic       ltSigned;
   logic       ltUnsigned;

   assign shAmt = opB[4:0]; // low 5 bits only
   assign ltSigned = $signed(opA) < $signed(opB);
   assign ltUnsigned = opA < opB;

   always_comb begin
      case (aluOp)
         ALU_ADD: begin
            aluResult = opA + opB;
         end
         ALU_SUB: begin
            aluResult = opA - opB;
         end
         ALU_XOR: begin
            aluResult = opA ^ opB;
         end
         ALU_OR: begin
            aluResult = opA | opB;
         end
         ALU_AND: begin
            aluResult = opA & opB;
         end
         ALU_SLT: begin
            aluResult = {31'b0, ltSigned};
         end
         ALU_SLTU: begin
            aluResult = {31'b0, ltUnsigned};
         end
         ALU_SLL: begin
            aluResult = opA << shAmt;
         end
         ALU_SRL: begin
            aluResult = opA >> shAmt;
         end
         ALU_SRA: begin
            aluResult = word_t'($signed(opA) >>> shAmt);
         end
         default: begin
            aluResult = opB; // PASSB
         end
      endcase
   end

endmodule

// File: rvCore.sv
`timescale 1ns/1ps

module rvCore import rvPkg::*; (
   input  logic    clk,
   input  logic    rstn,
   input  logic    start,
   output logic    halted,
   output memReq_t memReq,
   output logic    memReqValid,
   input  logic    memAck,
   input  word_t   memRData
);

   word_t    instr;
   decoded_t dec;
   word_t    rs1Data;
   word_t    rs2Data;
   word_t    opB;
   word_t    aluResult;
   logic     rfWEn;
   regAddr_t rfWAddr;
   word_t    rfWData;

   assign opB = dec.useImm ? dec.imm : rs2Data;

   rvSequencer uSeq (
      .clk         (clk),
      .rstn        (rstn),
      .start       (start),
      .halted      (halted),
      .instr       (instr),
      .dec         (dec),
      .aluResult   (aluResult),
      .rs2Data     (rs2Data),
      .memReq      (memReq),
      .memReqValid (memReqValid),
      .memAck      (memAck),
      .memRData    (memRData),
      .rfWEn       (rfWEn),
      .rfWAddr     (rfWAddr),
      .rfWData     (rfWData)
   );

   rvDecoder uDec (
      .instr (instr),
      .dec   (dec)
   );

   rvRegFile uRegs (
      .clk     (clk),
      .rstn    (rstn),
      .rs1     (dec.rs1),
      .rs2     (dec.rs2),
      .rs1Data (rs1Data),
      .rs2Data (rs2Data),
      .wEn     (rfWEn),
      .wAddr   (rfWAddr),
      .wData   (rfWData)
   );

   rvAlu uAlu (
      .opA       (rs1Data),
      .opB       (opB),
      .aluOp     (dec.aluOp),
      .aluResult (aluResult)
   );

endmodule

// File: rvDecoder.sv
`timescale 1ns/1ps

module rvDecoder import rvPkg::*; (
   input  word_t    instr,
   output decoded_t dec
);

   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   word_t      immI;
   word_t      immS;
   word_t      immU;
   word_t      shamt;
   logic       isShift;

   // funct3 encoding is shared by OP and OP-IMM
   function automatic aluOp_t baseOp(input logic [2:0] f3, input logic alt);
      case (f3)
         3'b000:  return alt ? ALU_SUB : ALU_ADD;
         3'b001:  return ALU_SLL;
         3'b010:  return ALU_SLT;
         3'b011:  return ALU_SLTU;
         3'b100:  return ALU_XOR;
         3'b101:  return alt ? ALU_SRA : ALU_SRL;
         3'b110:  return ALU_OR;
         default: return ALU_AND;
      endcase
   endfunction

   assign opcode = instr[6:0];
   assign funct3 = instr[14:12];
   assign funct7 = instr[31:25];

   assign immI = {{20{instr[31]}}, instr[31:20]};
   assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
   assign immU = {instr[31:12], 12'b0};
   assign shamt = {27'b0, instr[24:20]};
   assign isShift = (funct3 == 3'b001) || (funct3 == 3'b101);

   always_comb begin
      dec = '0;
      dec.aluOp = ALU_ADD;
      dec.rd = instr[11:7];
      dec.rs1 = instr[19:15];
      dec.rs2 = instr[24:20];
      dec.imm = immI;

      case (opcode)
         OPC_OP: begin
            dec.aluOp = baseOp(funct3, funct7 == F7_ALT);
            // alt funct7 only exists for SUB and SRA
            dec.invalid = !((funct7 == 7'b0) ||
                            (funct7 == F7_ALT && (funct3 == 3'b000 || funct3 == 3'b101)));
            dec.writesRd = !dec.invalid;
         end
         OPC_OPIMM: begin
            dec.useImm = 1'b1;
            dec.imm = isShift ? shamt : immI;
            dec.aluOp = baseOp(funct3, funct3 == 3'b101 && funct7 == F7_ALT);
            if (funct3 == 3'b001) begin
               dec.invalid = (funct7 != 7'b0);
            end else if (funct3 == 3'b101) begin
               dec.invalid = (funct7 != 7'b0) && (funct7 != F7_ALT);
            end
            dec.writesRd = !dec.invalid;
         end
         OPC_LUI: begin
            dec.aluOp = ALU_PASSB;
            dec.useImm = 1'b1;
            dec.imm = immU;
            dec.writesRd = 1'b1;
         end
         OPC_LOAD: begin
            dec.useImm = 1'b1;
            dec.invalid = (funct3 != F3_WORD); // word access only
            dec.isLoad = !dec.invalid;
            dec.writesRd = !dec.invalid;
         end
         OPC_STORE: begin
            dec.useImm = 1'b1;
            dec.imm = immS;
            dec.invalid = (funct3 != F3_WORD);
            dec.isStore = !dec.invalid;
         end
         OPC_HALT: begin
            dec.isHalt = 1'b1;
         end
         default: begin
            dec.invalid = 1'b1;
         end
      endcase
   end

endmodule

// File: rvPkg.sv
package rvPkg;

   localparam int XLEN = 32;
   localparam int NUM_REGS = 32;
   localparam int REG_ADDR_W = 5;

   // major opcodes, instr[6:0]
   localparam logic [6:0] OPC_OP = 7'b0110011;
   localparam logic [6:0] OPC_OPIMM = 7'b0010011;
   localparam logic [6:0] OPC_LUI = 7'b0110111;
   localparam logic [6:0] OPC_LOAD = 7'b0000011;
   localparam logic [6:0] OPC_STORE = 7'b0100011;
   localparam logic [6:0] OPC_HALT = 7'b1111111; // all ones stops the core

   localparam logic [2:0] F3_WORD = 3'b010;
   localparam logic [6:0] F7_ALT = 7'b0100000; // SUB / SRA / SRAI

   typedef logic [XLEN-1:0] word_t;
   typedef logic [REG_ADDR_W-1:0] regAddr_t;

   typedef enum logic [3:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_XOR,
      ALU_OR,
      ALU_AND,
      ALU_SLT,
      ALU_SLTU,
      ALU_SLL,
      ALU_SRL,
      ALU_SRA,
      ALU_PASSB // LUI
   } aluOp_t;

   typedef enum logic [1:0] {
      HALTED,
      FETCH,
      EXECUTE,
      MEMORY
   } seqState_t;

   typedef struct packed {
      aluOp_t   aluOp;
      regAddr_t rd;
      regAddr_t rs1;
      regAddr_t rs2;
      word_t    imm;      // already extended
      logic     useImm;
      logic     writesRd;
      logic     isLoad;
      logic     isStore;
      logic     isHalt;
      logic     invalid;
   } decoded_t;

   // word-addressed request, read when wEn is low
   typedef struct packed {
      word_t addr;
      word_t wData;
      logic  wEn;
   } memReq_t;

endpackage

// File: rvRegFile.sv
`timescale 1ns/1ps

module rvRegFile import rvPkg::*; (
   input  logic     clk,
   input  logic     rstn,
   input  regAddr_t rs1,
   input  regAddr_t rs2,
   output word_t    rs1Data,
   output word_t    rs2Data,
   input  logic     wEn,
   input  regAddr_t wAddr,
   input  word_t    wData
);

   // x0 is cleared at reset and never written
   word_t regs [0:NUM_REGS-1];

   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wEn && wAddr != '0) begin
         regs[wAddr] <= wData;
      end
   end

   assign rs1Data = regs[rs1];
   assign rs2Data = regs[rs2];

   assert property (@(posedge clk) disable iff (!rstn)
      (rs1 == '0) |-> (rs1Data == '0))
      else $error("x0 read back nonzero on rs1");

   assert property (@(posedge clk) disable iff (!rstn)
      (rs2 == '0) |-> (rs2Data == '0))
      else $error("x0 read back nonzero on rs2");

endmodule

// File: rvSequencer.sv
`timescale 1ns/1ps

module rvSequencer import rvPkg::*; (
   input  logic     clk,
   input  logic     rstn,
   input  logic     start,
   output logic     halted,
   output word_t    instr,
   input  decoded_t dec,
   input  word_t    aluResult,
   input  word_t    rs2Data,
   output memReq_t  memReq,
   output logic     memReqValid,
   input  logic     memAck,
   input  word_t    memRData,
   output logic     rfWEn,
   output regAddr_t rfWAddr,
   output word_t    rfWData
);

   seqState_t state;
   word_t     pc;
   word_t     ir;
   logic      xfer;
   logic      stop;

   assign xfer = memReqValid && memAck;
   assign stop = dec.isHalt || dec.invalid;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state <= HALTED;
         pc <= '0;
         memReqValid <= 1'b0;
      end else begin
         case (state)
            HALTED: begin
               if (start) begin
                  pc <= '0;
                  state <= FETCH;
               end
            end
            FETCH: begin
               // valid is low for a cycle after each transfer
               if (!memReqValid) begin
                  memReqValid <= 1'b1;
               end else if (memAck) begin
                  memReqValid <= 1'b0;
                  state <= EXECUTE;
               end
            end
            EXECUTE: begin
               if (stop) begin
                  state <= HALTED; // pc stays on the stopping instr
               end else if (dec.isLoad || dec.isStore) begin
                  state <= MEMORY;
               end else begin
                  pc <= pc + 1'b1;
                  state <= FETCH;
               end
            end
            MEMORY: begin
               if (!memReqValid) begin
                  memReqValid <= 1'b1;
               end else if (memAck) begin
                  memReqValid <= 1'b0;
                  pc <= pc + 1'b1;
                  state <= FETCH;
               end
            end
            default: begin
               state <= HALTED;
            end
         endcase
      end
   end

   // instruction register
   always_ff @(posedge clk) begin
      if (state == FETCH && xfer) begin
         ir <= memRData;
      end
   end

   assign instr = ir;
   assign halted = (state == HALTED);

   // aluResult is rs1 + imm during MEMORY
   assign memReq.addr = (state == MEMORY) ? aluResult : pc;
   assign memReq.wData = rs2Data;
   assign memReq.wEn = (state == MEMORY) && dec.isStore;

   assign rfWAddr = dec.rd;
   assign rfWData = (state == MEMORY) ? memRData : aluResult;
   assign rfWEn = (state == EXECUTE && !stop && dec.writesRd && !dec.isLoad) ||
                  (state == MEMORY && xfer && dec.isLoad);

   // request held until acked
   assert property (@(posedge clk) disable iff (!rstn)
      (memReqValid && !memAck) |=> (memReqValid && $stable(memReq)))
      else $error("memReq changed before memAck");

   assert property (@(posedge clk) disable iff (!rstn)
      !(halted && memReqValid))
      else $error("memory request while halted");

endmodule

// File: tbClockGen.sv
`timescale 1ns/1ps

module tbClockGen (
   output logic clk,
   output logic rstn
);

   localparam real HALF_PERIOD_NS = 10.0; // 20 ns clock
   localparam int RESET_CYCLES = 16;

   initial begin
      clk = 1'b0;
      forever #(HALF_PERIOD_NS) clk = ~clk;
   end

   initial begin
      rstn = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rstn = 1'b1;
   end

endmodule

// File: tbCore.sv
`timescale 1ns/1ps

module tbCore import rvPkg::*; ();

   localparam int MEM_WORDS = 1024;
   localparam int NUM_CASES = 24;
   localparam int NUM_DIRECTED = 4;
   localparam int CYCLES_PER_PROG = 100; // 7 instrs, each at most about 12 cycles
   localparam int CLK_NS = 20;
   localparam int WATCHDOG_NS = ((NUM_CASES + NUM_DIRECTED) * CYCLES_PER_PROG + 120) * CLK_NS;
   localparam word_t HALT_WORD = 32'h0000007f;

   typedef struct packed {
      aluOp_t op;
      word_t  a;
      word_t  b;      // 12-bit immediate in the low bits for the I form
      logic   useImm;
      word_t  stAddr;
      word_t  exp;
   } testCase_t;

   logic    clk;
   logic    rstn;
   logic    start;
   logic    halted;
   memReq_t memReq;
   logic    memReqValid;
   logic    memAck;
   word_t   memRData;

   word_t     mem [0:MEM_WORDS-1];
   word_t     prog [$];
   memReq_t   stores [$];
   testCase_t cases [NUM_CASES];
   int        numCases = 0;
   int        waitLeft = -1;

   tbClockGen clkGen (
      .clk  (clk),
      .rstn (rstn)
   );

   rvCore uut (
      .clk         (clk),
      .rstn        (rstn),
      .start       (start),
      .halted      (halted),
      .memReq      (memReq),
      .memReqValid (memReqValid),
      .memAck      (memAck),
      .memRData    (memRData)
   );

   function automatic word_t refAlu(aluOp_t op, word_t a, word_t b);
      logic [4:0] s;
      s = b[4:0];
      case (op)
         ALU_ADD:  return a + b;
         ALU_SUB:  return a + ~b + 32'd1;
         ALU_XOR:  return a ^ b;
         ALU_OR:   return a | b;
         ALU_AND:  return a & b;
         ALU_SLT:  return (a[31] != b[31]) ? word_t'(a[31]) : word_t'(a < b);
         ALU_SLTU: return word_t'(a < b);
         ALU_SLL:  return a << s;
         ALU_SRL:  return a >> s;
         ALU_SRA:  return (a >> s) | (a[31] ? ~(32'hffffffff >> s) : 32'h0);
         default:  return b;
      endcase
   endfunction

   // operand B as the ALU sees it
   function automatic word_t operandB(testCase_t tc);
      if (!tc.useImm) return tc.b;
      if (tc.op == ALU_PASSB) return {tc.b[31:12], 12'b0};
      return {{20{tc.b[11]}}, tc.b[11:0]};
   endfunction

   function automatic logic [2:0] funct3Of(aluOp_t op);
      case (op)
         ALU_SLL:          return 3'b001;
         ALU_SLT:          return 3'b010;
         ALU_SLTU:         return 3'b011;
         ALU_XOR:          return 3'b100;
         ALU_SRL, ALU_SRA: return 3'b101;
         ALU_OR:           return 3'b110;
         ALU_AND:          return 3'b111;
         default:          return 3'b000;
      endcase
   endfunction

   function automatic word_t encR(logic [6:0] f7, regAddr_t rs2, regAddr_t rs1,
                                  logic [2:0] f3, regAddr_t rd);
      return {f7, rs2, rs1, f3, rd, OPC_OP};
   endfunction

   function automatic word_t encI(logic [11:0] imm, regAddr_t rs1, logic [2:0] f3,
                                  regAddr_t rd, logic [6:0] opc);
      return {imm, rs1, f3, rd, opc};
   endfunction

   function automatic word_t encS(logic [11:0] imm, regAddr_t rs2, regAddr_t rs1);
      return {imm[11:5], rs2, rs1, F3_WORD, imm[4:0], OPC_STORE};
   endfunction

   task automatic checkWord(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         $display("** Error %s: got 0x%h, expected 0x%h", name, got, exp);
         $display("Simulation FAILED");
         $fatal(1, "value mismatch on %s", name);
      end
   endtask

   task automatic checkHalted(input bit got, input bit exp);
      if (got !== exp) begin
         $display("** Error halted: got 0x%h, expected 0x%h", got, exp);
         $display("Simulation FAILED");
         $fatal(1, "value mismatch on halted");
      end
   endtask

   task automatic addCase(input aluOp_t op, input word_t a, input word_t b, input logic useImm);
      testCase_t tc;
      tc.op = op;
      tc.a = a;
      tc.b = b;
      tc.useImm = useImm;
      tc.stAddr = 64 + numCases; // clear of the program words
      tc.exp = refAlu(op, a, operandB(tc));
      cases[numCases] = tc;
      numCases++;
   endtask

   // LUI + ADDI, upper part rounded for the signed low 12 bits
   task automatic pushConst(input regAddr_t rd, input word_t val);
      word_t hi;
      hi = val + 32'h800;
      prog.push_back({hi[31:12], rd, OPC_LUI});
      prog.push_back(encI(val[11:0], rd, 3'b000, rd, OPC_OPIMM));
   endtask

   task automatic buildAluProgram(input testCase_t tc);
      logic [6:0]  f7;
      logic [11:0] imm;
      f7 = (tc.op == ALU_SUB || tc.op == ALU_SRA) ? F7_ALT : 7'b0;
      prog.delete();
      pushConst(5'd1, tc.a);
      if (tc.op == ALU_PASSB) begin
         prog.push_back({tc.b[31:12], 5'd3, OPC_LUI});
      end else if (tc.useImm) begin
         if (tc.op == ALU_SLL || tc.op == ALU_SRL || tc.op == ALU_SRA) begin
            imm = {f7, tc.b[4:0]};
         end else begin
            imm = tc.b[11:0];
         end
         prog.push_back(encI(imm, 5'd1, funct3Of(tc.op), 5'd3, OPC_OPIMM));
      end else begin
         pushConst(5'd2, tc.b);
         prog.push_back(encR(f7, 5'd2, 5'd1, funct3Of(tc.op), 5'd3));
      end
      prog.push_back(encS(tc.stAddr[11:0], 5'd3, 5'd0));
      prog.push_back(HALT_WORD);
   endtask

   task automatic runProgram();
      stores.delete();
      foreach (prog[i]) mem[i] = prog[i];
      @(negedge clk);
      start = 1'b1;
      @(negedge clk);
      start = 1'b0;
      checkHalted(halted, 1'b0);
      while (!memReqValid) @(negedge clk);
      checkWord("fetch addr", memReq.addr, '0); // every program starts at word 0
      checkWord("fetch wEn", word_t'(memReq.wEn), '0);
      while (!halted) @(negedge clk);
      checkWord("memReqValid", word_t'(memReqValid), '0);
   endtask

   task automatic expectStore(input int idx, input word_t addr, input word_t data);
      checkWord("store addr", stores[idx].addr, addr);
      checkWord("store data", stores[idx].wData, data);
   endtask

   // nothing may be stored once the core stops
   task automatic stopTest(input word_t stopWord);
      prog.delete();
      pushConst(5'd1, 32'h00c0ffee);
      prog.push_back(stopWord);
      prog.push_back(encS(12'd211, 5'd1, 5'd0));
      prog.push_back(HALT_WORD);
      runProgram();
      checkWord("storeCount", word_t'(stores.size()), 32'd0);
   endtask

   // memory model, ack after 0 to 3 cycles
   initial begin
      void'($urandom(32'h4a498f00));
      forever begin
         @(negedge clk);
         if (!rstn) begin
            memAck = 1'b0;
            waitLeft = -1;
         end else if (memAck) begin
            memAck = 1'b0; // transfer done at the last rising edge
         end else if (memReqValid) begin
            if (waitLeft < 0) waitLeft = $urandom_range(3, 0);
            if (waitLeft == 0) begin
               if (memReq.wEn) begin
                  mem[memReq.addr[9:0]] = memReq.wData;
                  stores.push_back(memReq);
               end else begin
                  memRData = mem[memReq.addr[9:0]];
               end
               memAck = 1'b1;
            end
            waitLeft--;
         end
      end
   end

   initial begin
      #(WATCHDOG_NS);
      $display("core did not halt within %0d ns", WATCHDOG_NS);
      $display("Simulation FAILED");
      $fatal(1, "watchdog expired");
   end

   initial begin
      start = 1'b0;
      memAck = 1'b0;
      memRData = '0;
      for (int i = 0; i < MEM_WORDS; i++) mem[i] = 32'h5a5a0000 ^ (word_t'(i) * 32'h9e3779b1);

      addCase(ALU_ADD, 32'h7fffffff, 32'h00000001, 1'b0);
      addCase(ALU_SUB, 32'h00000005, 32'h00000007, 1'b0);
      addCase(ALU_XOR, 32'hf0f0a5a5, 32'h0ff05a5a, 1'b0);
      addCase(ALU_OR, 32'h12340000, 32'h00005678, 1'b0);
      addCase(ALU_AND, 32'hffff00ff, 32'h0f0f0f0f, 1'b0);
      addCase(ALU_SLT, 32'hffffffff, 32'h00000001, 1'b0);
      addCase(ALU_SLT, 32'h00000005, 32'hfffffffd, 1'b0);
      addCase(ALU_SLTU, 32'hffffffff, 32'h00000001, 1'b0);
      addCase(ALU_SLTU, 32'h00000001, 32'hffffffff, 1'b0);
      addCase(ALU_SLL, 32'h00000003, 32'h00000023, 1'b0); // only low 5 bits count
      addCase(ALU_SRL, 32'h80000000, 32'h0000001f, 1'b0);
      addCase(ALU_SRA, 32'h80000010, 32'h00000004, 1'b0);
      addCase(ALU_SRA, 32'hc0000000, 32'h0000001f, 1'b0);
      addCase(ALU_ADD, 32'h00000100, 32'h00000fff, 1'b1);
      addCase(ALU_XOR, 32'h12345678, 32'h00000800, 1'b1);
      addCase(ALU_OR, 32'h80000000, 32'h000007ff, 1'b1);
      addCase(ALU_AND, 32'hffffffff, 32'h00000ff0, 1'b1);
      addCase(ALU_SLT, 32'hfffffffb, 32'h00000ffc, 1'b1);
      addCase(ALU_SLTU, 32'h00000003, 32'h00000fff, 1'b1);
      addCase(ALU_SLL, 32'h00000001, 32'h0000001f, 1'b1);
      addCase(ALU_SRL, 32'hffffffff, 32'h0000001f, 1'b1);
      addCase(ALU_SRA, 32'h80000000, 32'h0000001f, 1'b1);
      addCase(ALU_PASSB, 32'h00000000, 32'habcde000, 1'b1);
      addCase(ALU_PASSB, 32'h00000000, 32'hfffff000, 1'b1);

      @(posedge rstn);
      repeat (4) begin
         @(negedge clk);
         checkHalted(halted, 1'b1);
         checkWord("memReqValid", word_t'(memReqValid), '0);
      end

      stopTest(HALT_WORD);
      stopTest(32'h00000083); // LB is not supported

      for (int i = 0; i < NUM_CASES; i++) begin
         buildAluProgram(cases[i]);
         runProgram();
         checkWord("storeCount", word_t'(stores.size()), 32'd1);
         expectStore(0, cases[i].stAddr, cases[i].exp);
      end

      // SW, LW back, SW again
      prog.delete();
      pushConst(5'd1, 32'hcafe8123);
      prog.push_back(encS(12'd200, 5'd1, 5'd0));
      prog.push_back(encI(12'd200, 5'd0, F3_WORD, 5'd5, OPC_LOAD));
      prog.push_back(encS(12'd201, 5'd5, 5'd0));
      prog.push_back(HALT_WORD);
      runProgram();
      checkWord("storeCount", word_t'(stores.size()), 32'd2);
      expectStore(0, 32'd200, 32'hcafe8123);
      expectStore(1, 32'd201, 32'hcafe8123);

      // writes to x0 are dropped
      prog.delete();
      pushConst(5'd1, 32'h0f0f1234);
      prog.push_back(encR(7'b0, 5'd1, 5'd1, 3'b000, 5'd0));
      prog.push_back(encS(12'd300, 5'd0, 5'd0));
      prog.push_back(HALT_WORD);
      runProgram();
      checkWord("storeCount", word_t'(stores.size()), 32'd1);
      expectStore(0, 32'd300, 32'h0);

      $display("Simulation PASSED");
      $finish;
   end

endmodule

// File: verilog.f
rvPkg.sv
rvDecoder.sv
rvAlu.sv
rvRegFile.sv
rvSequencer.sv
rvCore.sv
tbClockGen.sv
tbCore.sv
